//--- mmio_subsystem.f
rtl/mmio_pkg.sv
rtl/mmio_bus_if.sv
rtl/io_script_master.sv
rtl/mmio_decoder.sv
rtl/display_regs.sv
rtl/scratch_ram.sv
rtl/mmio_subsystem.sv
test/mmio_subsystem_properties.sv
test/mmio_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, result taken from sim.log

verilator --binary --timing --assert -f mmio_subsystem.f \
	--top-module mmio_subsystem_tb --Mdir obj_dir > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vmmio_subsystem_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0

//--- test/mmio_subsystem_tb.sv
module mmio_subsystem_tb
	import mmio_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int cycle_delay = 3;
	localparam int clk_period = 100;
	localparam int reset_cycles = 5;
	localparam int rounds = 4;
	localparam int cmds_per_round = 2 * script_len; // Write pass plus read pass
	localparam int stall_allow = 8;                 // Extra cycles per command under stall
	localparam int watchdog_cycles =
		reset_cycles + rounds * cmds_per_round * (cycle_delay + 2 + stall_allow);

	logic clk = 1'b0;
	logic rst;
	logic io_stall = 1'b0;
	logic error;
	logic round_done;
	logic display_on;
	logic [data_width-1:0] display_ptr;
	logic cmd_valid;
	logic cmd_ready;

	logic [31:0] lfsr_state = 32'ha1b33a42;
	int rounds_seen = 0;        // round_done pulses so far
	int unsigned assert_fails;

	mmio_subsystem #(
		.cycle_delay(cycle_delay)
	) i_dut (
		.clk(clk),
		.rst(rst),
		.io_stall(io_stall),
		.error(error),
		.round_done(round_done),
		.display_on(display_on),
		.display_ptr(display_ptr),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready)
	);

	////////////////////////////////////////
	// Clock and reset
	////////////////////////////////////////

	initial
	begin
		forever #(clk_period / 2) clk = ~clk;
	end

	initial
	begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
	end

	////////////////////////////////////////
	// Stall stimulus
	////////////////////////////////////////

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	always @(posedge clk)
	begin
		logic bit_a;
		logic bit_b;
		if (rst)
			io_stall <= 1'b0;
		else if (rounds_seen == 1 || rounds_seen == 2) // Rounds 2 and 3
		begin
			lfsr_state = lfsr_next(lfsr_state);
			bit_a = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
			bit_b = lfsr_state[0];
			io_stall <= bit_a && bit_b;  // About one cycle in four
		end
		else
			io_stall <= 1'b0;
	end

	always @(posedge clk)
	begin
		if (!rst && round_done)
			rounds_seen <= rounds_seen + 1;
	end

	////////////////////////////////////////
	// End of run and watchdog
	////////////////////////////////////////

	initial
	begin
		wait (rounds_seen == rounds);
		repeat (2) @(posedge clk);         // Let the last assertions sample
		assert_fails = i_dut.i_props.fail_count;
		$display("Assertion failures: %0d, round_done pulses: %0d of %0d",
			assert_fails, rounds_seen, rounds);
		if (assert_fails == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, round_done arrived %0d of %0d times",
			watchdog_cycles, rounds_seen, rounds);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- test/mmio_subsystem_properties.sv
module mmio_subsystem_properties
	import mmio_pkg::*;
#(
	parameter int cycle_delay = 1000
)
(
	input logic clk,
	input logic rst,
	input logic io_stall,
	input logic error,
	input logic round_done,
	input logic display_on,
	input logic [data_width-1:0] display_ptr,
	input logic cmd_valid,
	input logic cmd_ready
);

	timeunit 1ns;
	timeprecision 1ps;

	// Last value written to an address within one write pass
	function automatic logic [data_width-1:0] last_write(input logic [addr_width-1:0] a);
		logic [data_width-1:0] v;
		v = '0;
		for (int i = 0; i < script_len; i++)
			if (script_table[i].addr == a)
				v = script_table[i].wdata;
		return v;
	endfunction

	localparam logic [data_width-1:0] exp_ptr = last_write(display_ptr_addr);
	localparam logic [data_width-1:0] exp_ctrl = last_write(display_ctrl_addr);

	int unsigned fail_count = 0; // Failed assertions so far
	int unsigned gap_cnt;        // Idle cycles since the last cmd_ready
	logic after_ready;           // No gap to measure before the first ready

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			gap_cnt <= 0;
			after_ready <= 1'b0;
		end
		else if (cmd_ready)
		begin
			gap_cnt <= 0;
			after_ready <= 1'b1;
		end
		else if (!cmd_valid)
			gap_cnt <= gap_cnt + 1;
	end

	////////////////////////////////////////
	// Read-back and display state
	////////////////////////////////////////

	a_no_error: assert property (@(posedge clk) disable iff (rst) !error)
		else
		begin
			fail_count++;
			$error("Read-back mismatch raised the error flag");
		end

	a_disp_on: assert property (@(posedge clk) disable iff (rst)
		round_done |-> (display_on == exp_ctrl[0]))
		else
		begin
			fail_count++;
			$error("[ERROR] %0t display_on: expected %b, got %b",
				$time, exp_ctrl[0], display_on);
		end

	a_disp_ptr: assert property (@(posedge clk) disable iff (rst)
		round_done |-> (display_ptr == exp_ptr))
		else
		begin
			fail_count++;
			$error("[ERROR] %0t display_ptr: expected %h, got %h",
				$time, exp_ptr, display_ptr);
		end

	////////////////////////////////////////
	// Handshake, pacing, back-pressure
	////////////////////////////////////////

	a_hold: assert property (@(posedge clk) disable iff (rst)
		(cmd_valid && !cmd_ready) |=> cmd_valid)
		else
		begin
			fail_count++;
			$error("cmd_valid dropped before cmd_ready");
		end

	a_orphan: assert property (@(posedge clk) disable iff (rst) cmd_ready |-> cmd_valid)
		else
		begin
			fail_count++;
			$error("cmd_ready seen without cmd_valid");
		end

	a_drop: assert property (@(posedge clk) disable iff (rst) cmd_ready |=> !cmd_valid)
		else
		begin
			fail_count++;
			$error("cmd_valid still high after cmd_ready");
		end

	a_pace: assert property (@(posedge clk) disable iff (rst)
		(after_ready && $rose(cmd_valid)) |-> (gap_cnt == cycle_delay))
		else
		begin
			fail_count++;
			$error("[ERROR] %0t pace gap: expected %0d, got %0d",
				$time, cycle_delay, gap_cnt);
		end

	// Accept needs a stall-free cycle two cycles before ready
	a_stall: assert property (@(posedge clk) disable iff (rst)
		cmd_ready |-> !($past(io_stall, 1) && $past(io_stall, 2)))
		else
		begin
			fail_count++;
			$error("cmd_ready arrived through a full stall");
		end

	a_reset: assert property (@(posedge clk)
		$fell(rst) |-> (!error && !round_done && !cmd_ready && !display_on))
		else
		begin
			fail_count++;
			$error("Status outputs not low right after reset");
		end

endmodule

bind mmio_subsystem mmio_subsystem_properties #(
	.cycle_delay(cycle_delay)
) i_props (
	.clk(clk),
	.rst(rst),
	.io_stall(io_stall),
	.error(error),
	.round_done(round_done),
	.display_on(display_on),
	.display_ptr(display_ptr),
	.cmd_valid(cmd_valid),
	.cmd_ready(cmd_ready)
);

//--- rtl/mmio_subsystem.sv
module mmio_subsystem
	import mmio_pkg::*;
#(
	parameter int cycle_delay = 1000,
	parameter int ram_words = 16
)
(
	input logic clk,
	input logic rst,
	input logic io_stall,
	output logic error,
	output logic round_done,
	output logic display_on,
	output logic [data_width-1:0] display_ptr,
	output logic cmd_valid,
	output logic cmd_ready
);

	mmio_bus_if req_bus ();   // Master to decoder
	mmio_bus_if disp_bus ();  // Decoder to display regs
	mmio_bus_if ram_bus ();   // Decoder to scratch RAM

	////////////////////////////////////////
	// Command path
	////////////////////////////////////////

	io_script_master #(
		.cycle_delay(cycle_delay)
	) i_master (
		.clk(clk),
		.rst(rst),
		.bus(req_bus),
		.error(error),
		.round_done(round_done)
	);

	mmio_decoder i_decoder (
		.clk(clk),
		.rst(rst),
		.io_stall(io_stall),
		.up(req_bus),
		.disp(disp_bus),
		.ram(ram_bus)
	);

	display_regs i_display (
		.clk(clk),
		.rst(rst),
		.bus(disp_bus),
		.display_on(display_on),
		.display_ptr(display_ptr)
	);

	scratch_ram #(
		.ram_words(ram_words)
	) i_ram (
		.clk(clk),
		.bus(ram_bus)
	);

	// Handshake brought out for observation
	assign cmd_valid = req_bus.valid;
	assign cmd_ready = req_bus.ready;

endmodule

//--- rtl/scratch_ram.sv
module scratch_ram
	import mmio_pkg::*;
#(
	parameter int ram_words = 16
)
(
	input logic clk,
	mmio_bus_if.target bus
);

	localparam int idx_w = $clog2(ram_words);

	logic [data_width-1:0] mem [ram_words];
	logic [data_width-1:0] rdata_q;
	logic [idx_w-1:0] word;    // Low address bits, upper bits alias
	logic ready_q;

	assign word = bus.addr[idx_w-1:0];

	always_ff @(posedge clk)
	begin
		if (bus.valid && (bus.op == op_write))
			mem[word] <= bus.wdata;
		rdata_q <= mem[word];   // Old data on a write, unused there
	end

	// Answer one cycle after strobe
	always_ff @(posedge clk)
	begin
		ready_q <= bus.valid;
	end

	assign bus.ready = ready_q;
	assign bus.rdata = rdata_q;

endmodule

//--- rtl/display_regs.sv
module display_regs
	import mmio_pkg::*;
(
	input logic clk,
	input logic rst,
	mmio_bus_if.target bus,
	output logic display_on,
	output logic [data_width-1:0] display_ptr
);

	logic [data_width-1:0] ptr_q;   // Frame start address
	logic [data_width-1:0] ctrl_q;  // Control word
	logic [data_width-1:0] rdata_q;
	logic ready_q;
	logic wr;

	assign wr = bus.valid && (bus.op == op_write);

	////////////////////////////////////////
	// Registers
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ptr_q <= '0;
			ctrl_q <= '0;   // Display off
			ready_q <= 1'b0;
		end
		else
		begin
			ready_q <= bus.valid;  // Answer one cycle after strobe
			if (wr)
			begin
				if (bus.addr == display_ptr_addr)
					ptr_q <= bus.wdata;
				else if (bus.addr == display_ctrl_addr)
					ctrl_q <= bus.wdata;
				// Other display addresses drop the write
			end
		end
	end

	// Read-back
	always_ff @(posedge clk)
	begin
		if (bus.valid)
		begin
			case (bus.addr)
				display_ptr_addr: rdata_q <= ptr_q;
				display_ctrl_addr: rdata_q <= ctrl_q;
				default: rdata_q <= '0;   // Unused hole reads zero
			endcase
		end
	end

	assign bus.ready = ready_q;
	assign bus.rdata = rdata_q;

	assign display_on = ctrl_q[0];
	assign display_ptr = ptr_q;

endmodule

//--- rtl/mmio_decoder.sv
module mmio_decoder
	import mmio_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic io_stall,     // Back-pressure, blocks acceptance
	mmio_bus_if.target up,
	mmio_bus_if.master disp,
	mmio_bus_if.master ram
);

	logic busy;                // Request between accept and ready
	logic strobe;              // Target strobe, one cycle after accept
	logic sel_disp;            // Latched route, display when set
	logic accept;
	logic tgt_ready;

	cmd_op_e req_op;
	logic [addr_width-1:0] req_addr;
	logic [data_width-1:0] req_wdata;

	assign accept = up.valid && !busy && !io_stall;

	////////////////////////////////////////
	// Decode stage
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			strobe <= 1'b0;
			sel_disp <= 1'b0;
		end
		else
		begin
			strobe <= accept;
			if (accept)
			begin
				busy <= 1'b1;
				// Top nibble picks the target, anything outside display hits the RAM
				sel_disp <= (up.addr[addr_width-1 -: 4] == display_base);
			end
			else if (up.ready)
			begin
				busy <= 1'b0;  // Response handed back
			end
		end
	end

	// Request payload
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			req_op <= up.op;
			req_addr <= up.addr;
			req_wdata <= up.wdata;
		end
	end

	////////////////////////////////////////
	// Target side
	////////////////////////////////////////

	assign disp.valid = strobe && sel_disp;
	assign disp.op = req_op;
	assign disp.addr = req_addr;
	assign disp.wdata = req_wdata;

	assign ram.valid = strobe && !sel_disp;
	assign ram.op = req_op;
	assign ram.addr = req_addr;
	assign ram.wdata = req_wdata;

	// Response mux, ready only while a request is held
	assign tgt_ready = sel_disp ? disp.ready : ram.ready;
	assign up.ready = busy && tgt_ready;
	assign up.rdata = sel_disp ? disp.rdata : ram.rdata;

endmodule

//--- rtl/io_script_master.sv
module io_script_master
	import mmio_pkg::*;
#(
	parameter int cycle_delay = 1000 // Idle cycles between commands, at least 1
)
(
	input logic clk,
	input logic rst,
	mmio_bus_if.master bus,
	output logic error,
	output logic round_done
);

	localparam int idx_w = $clog2(script_len);
	localparam int pace_w = $clog2(cycle_delay + 1);
	localparam logic [idx_w-1:0] last_idx = idx_w'(script_len - 1);
	localparam logic [pace_w-1:0] pace_last = pace_w'(cycle_delay - 1);

	master_state_e state;
	pass_e pass;
	logic [idx_w-1:0] idx;      // Current script entry
	logic [pace_w-1:0] pace_cnt;
	logic valid_q;
	logic cmd_done;             // Current command completes this cycle
	logic rd_check;             // Read response to compare
	script_entry_t entry;

	////////////////////////////////////////
	// Command outputs
	////////////////////////////////////////

	assign entry = script_table[idx];

	// Entry held stable while valid, idx only moves on ready
	assign bus.valid = valid_q;
	assign bus.op = (pass == pass_write) ? op_write : op_read;
	assign bus.addr = entry.addr;
	assign bus.wdata = entry.wdata;

	assign cmd_done = (state == st_wait_ready) && bus.ready;
	assign rd_check = cmd_done && (pass == pass_read);

	// Last read of the round
	assign round_done = rd_check && (idx == last_idx);

	////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= st_issue;   // First write goes out right after reset
			pass <= pass_write;
			idx <= '0;
			pace_cnt <= '0;
			valid_q <= 1'b0;
		end
		else
		begin
			case (state)
				st_issue:
				begin
					valid_q <= 1'b1;
					state <= st_wait_ready;
				end

				st_wait_ready:
				begin
					if (bus.ready)
					begin
						valid_q <= 1'b0;  // Drop in the cycle after ready
						pace_cnt <= '0;
						state <= st_pace;
						if (idx == last_idx)
						begin
							// Wrap and switch pass
							idx <= '0;
							pass <= (pass == pass_write) ? pass_read : pass_write;
						end
						else
						begin
							idx <= idx + 1'b1;
						end
					end
				end

				st_pace:
				begin
					// Valid rises straight from pacing so the gap is exactly cycle_delay
					if (pace_cnt == pace_last)
					begin
						valid_q <= 1'b1;
						state <= st_wait_ready;
					end
					else
					begin
						pace_cnt <= pace_cnt + 1'b1;
					end
				end

				default:
				begin
					valid_q <= 1'b0;
					state <= st_issue;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Read-back check
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			error <= 1'b0;
		else if (rd_check && (bus.rdata != entry.expected))
			error <= 1'b1; // Sticky until reset
	end

endmodule

//--- rtl/mmio_bus_if.sv
interface mmio_bus_if
	import mmio_pkg::*;
();

	// Request side
	logic valid;
	cmd_op_e op;
	logic [addr_width-1:0] addr;
	logic [data_width-1:0] wdata;

	// Response side
	logic ready;                 // One cycle pulse
	logic [data_width-1:0] rdata; // Valid with ready on reads

	modport master (
		output valid, op, addr, wdata,
		input ready, rdata
	);

	modport target (
		input valid, op, addr, wdata,
		output ready, rdata
	);

endinterface

//--- rtl/mmio_pkg.sv
package mmio_pkg;

	////////////////////////////////////////
	// Bus widths and address map
	////////////////////////////////////////

	localparam int data_width = 32;
	localparam int addr_width = 28;

	localparam logic [3:0] display_base = 4'h8;            // Top nibble of display region
	localparam logic [addr_width-1:0] display_ptr_addr = 28'h800_0004;  // Frame start pointer
	localparam logic [addr_width-1:0] display_ctrl_addr = 28'h800_0005; // Bit 0 is display on

	////////////////////////////////////////
	// Enums
	////////////////////////////////////////

	typedef enum logic {op_read, op_write} cmd_op_e;

	typedef enum logic [1:0] {st_issue, st_wait_ready, st_pace} master_state_e;

	typedef enum logic {pass_write, pass_read} pass_e;

	////////////////////////////////////////
	// Command script
	////////////////////////////////////////

	localparam int script_len = 9;

	// Final register values once a write pass completes
	localparam logic [data_width-1:0] ptr_final = 32'h0020_0000;
	localparam logic [data_width-1:0] ctrl_final = 32'h0000_0001;

	typedef struct packed {
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] wdata;
		logic [data_width-1:0] expected; // Last value written to addr in the pass
	} script_entry_t;

	localparam script_entry_t script_table [script_len] = '{
		'{display_ptr_addr,  32'h0000_0000, ptr_final},      // Start address
		'{display_ctrl_addr, 32'h0000_0000, ctrl_final},     // Display off
		'{28'h000_0002,      32'ha5a5_0002, 32'ha5a5_0002},  // Scratch word 2
		'{display_ctrl_addr, 32'h0100_0001, ctrl_final},
		'{display_ptr_addr,  32'h0010_0000, ptr_final},
		'{28'h000_0007,      32'h5a5a_0007, 32'h5a5a_0007},  // Scratch word 7
		'{display_ptr_addr,  ptr_final,     ptr_final},      // Last pointer write
		'{28'h000_000f,      32'hc3c3_000f, 32'hc3c3_000f},  // Scratch word 15
		'{display_ctrl_addr, ctrl_final,    ctrl_final}      // Display on
	};

endpackage
